/* Makefile */
VERILATOR  ?= verilator
TOP        := decode_stage_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+src
src/decode_pkg.sv
src/rv_field_decoder.sv
src/reg_scoreboard.sv
src/reg_file.sv
src/issue_control.sv
src/decode_stage.sv
verification/decode_stage_tb.sv

/* src/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Architectural register count, also the length of the reset clear
`define DEC_NUM_REGS 32

// Register and pc width
`define DEC_XLEN 32

// Jump epoch counter width
`define DEC_JUMP_FLAG_W 2

// Link address offset for JAL and JALR
`define DEC_PC_STEP 4

`endif

/* src/decode_pkg.sv */
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [$clog2(`DEC_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [`DEC_XLEN-1:0] reg_value_t;
    typedef logic [`DEC_JUMP_FLAG_W-1:0] jump_flag_t;

    // RV32I major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_IMM    = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_FENCE  = 7'b0001111,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [1:0] {
        CLASS_ALU     = 2'b00,
        CLASS_JUMP    = 2'b01,
        CLASS_HALT    = 2'b10,
        CLASS_ILLEGAL = 2'b11
    } instr_class_t;

    typedef enum logic [1:0] {
        STATE_RESET  = 2'b00,
        STATE_NORMAL = 2'b01,
        STATE_HALT   = 2'b10,
        STATE_FAULT  = 2'b11
    } decode_state_t;

    // Pending counts are writes already sent to execute
    typedef enum logic [1:0] {
        REG_VALID       = 2'b00,
        REG_INVALID     = 2'b01,
        REG_PENDING_ONE = 2'b10,
        REG_PENDING_TWO = 2'b11
    } reg_status_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000, // SUB with alternate
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101, // SRA with alternate
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

endpackage

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [31:0]            instr_word,
    input  decode_pkg::reg_value_t instr_pc,
    input  decode_pkg::jump_flag_t instr_jump_flag,
    output logic                   instr_ready,
    input  logic                   wb_valid,
    input  decode_pkg::reg_addr_t  wb_addr,
    input  decode_pkg::reg_value_t wb_value,
    output logic                   exec_valid,
    output decode_pkg::reg_addr_t  exec_rd,
    output decode_pkg::alu_op_t    exec_op,
    output logic                   exec_alternate,
    output decode_pkg::reg_value_t exec_operand_a,
    output decode_pkg::reg_value_t exec_operand_b,
    output decode_pkg::reg_value_t exec_pc,
    output logic                   jump_valid,
    output decode_pkg::reg_value_t jump_base,
    output decode_pkg::reg_value_t jump_offset,
    output logic                   retired,
    output logic                   finished,
    output logic                   faulted
);

    decode_pkg::opcode_t      opcode;
    decode_pkg::reg_addr_t    rd;
    decode_pkg::reg_addr_t    rs1;
    decode_pkg::reg_addr_t    rs2;
    decode_pkg::alu_op_t      funct3;
    logic                     funct7_alt;
    decode_pkg::reg_value_t   imm;
    decode_pkg::instr_class_t instr_class;

    decode_pkg::reg_value_t rs1_value;
    decode_pkg::reg_value_t rs2_value;
    logic                   rs_ready;
    logic                   all_clear;
    logic                   issue;
    logic                   clear;
    decode_pkg::reg_addr_t  clear_addr;

    rv_field_decoder rv_field_decoder_inst (
        .instr_word, .opcode, .rd, .rs1, .rs2, .funct3, .funct7_alt, .imm, .instr_class
    );

    reg_file reg_file_inst (
        .clk, .clear, .clear_addr, .wb_valid, .wb_addr, .wb_value,
        .rd_addr_a(rs1), .rd_addr_b(rs2),
        .rd_data_a(rs1_value), .rd_data_b(rs2_value)
    );

    reg_scoreboard reg_scoreboard_inst (
        .clk, .rst, .opcode, .rd, .rs1, .rs2, .issue,
        .wb_valid, .wb_addr, .rs_ready, .all_clear
    );

    issue_control issue_control_inst (
        .clk, .rst, .instr_valid, .instr_pc, .instr_jump_flag,
        .opcode, .rd, .funct3, .funct7_alt, .imm, .instr_class,
        .rs_ready, .all_clear, .rs1_value, .rs2_value,
        .instr_ready, .issue, .clear, .clear_addr,
        .exec_valid, .exec_rd, .exec_op, .exec_alternate,
        .exec_operand_a, .exec_operand_b, .exec_pc,
        .jump_valid, .jump_base, .jump_offset,
        .retired, .finished, .faulted
    );

endmodule

/* src/issue_control.sv */
`timescale 1ns/1ps

`include "decode_consts.svh"

module issue_control (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  decode_pkg::reg_value_t   instr_pc,
    input  decode_pkg::jump_flag_t   instr_jump_flag,
    input  decode_pkg::opcode_t      opcode,
    input  decode_pkg::reg_addr_t    rd,
    input  decode_pkg::alu_op_t      funct3,
    input  logic                     funct7_alt,
    input  decode_pkg::reg_value_t   imm,
    input  decode_pkg::instr_class_t instr_class,
    input  logic                     rs_ready,
    input  logic                     all_clear,
    input  decode_pkg::reg_value_t   rs1_value,
    input  decode_pkg::reg_value_t   rs2_value,
    output logic                     instr_ready,
    output logic                     issue,
    output logic                     clear,
    output decode_pkg::reg_addr_t    clear_addr,
    output logic                     exec_valid,
    output decode_pkg::reg_addr_t    exec_rd,
    output decode_pkg::alu_op_t      exec_op,
    output logic                     exec_alternate,
    output decode_pkg::reg_value_t   exec_operand_a,
    output decode_pkg::reg_value_t   exec_operand_b,
    output decode_pkg::reg_value_t   exec_pc,
    output logic                     jump_valid,
    output decode_pkg::reg_value_t   jump_base,
    output decode_pkg::reg_value_t   jump_offset,
    output logic                     retired,
    output logic                     finished,
    output logic                     faulted
);

    decode_pkg::decode_state_t state;
    decode_pkg::jump_flag_t    jump_flag;
    decode_pkg::reg_addr_t     clear_count;

    logic flag_match;
    logic accept;
    logic is_jump;

    decode_pkg::alu_op_t    op_sel;
    logic                   alt_sel;
    decode_pkg::reg_value_t a_sel;
    decode_pkg::reg_value_t b_sel;

    assign flag_match  = (instr_jump_flag == jump_flag);
    // Stale-epoch words are always taken so they can be dropped
    assign instr_ready = (state == decode_pkg::STATE_NORMAL) && (!flag_match || rs_ready);
    assign accept      = instr_valid && instr_ready && flag_match;
    assign is_jump     = (instr_class == decode_pkg::CLASS_JUMP);
    assign issue       = accept && (is_jump || instr_class == decode_pkg::CLASS_ALU);

    assign clear      = (state == decode_pkg::STATE_RESET);
    assign clear_addr = clear_count;
    assign faulted    = (state == decode_pkg::STATE_FAULT);
    assign finished   = (faulted || state == decode_pkg::STATE_HALT) && all_clear;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= decode_pkg::STATE_RESET;
            clear_count <= '0;
            jump_flag   <= '0;
        end else begin
            case (state)
                decode_pkg::STATE_RESET: begin
                    clear_count <= clear_count + 1'b1;
                    if (clear_count == decode_pkg::reg_addr_t'(`DEC_NUM_REGS - 1)) begin
                        state <= decode_pkg::STATE_NORMAL;
                    end
                end
                decode_pkg::STATE_NORMAL: begin
                    if (accept && instr_class == decode_pkg::CLASS_HALT) begin
                        state <= decode_pkg::STATE_HALT;
                    end else if (accept && instr_class == decode_pkg::CLASS_ILLEGAL) begin
                        state <= decode_pkg::STATE_FAULT;
                    end
                end
                default: begin
                    state <= state; // Halt and fault hold until reset
                end
            endcase
            if (issue && is_jump) begin
                jump_flag <= jump_flag + 1'b1; // New epoch after every jump
            end
        end
    end

    always_comb begin
        op_sel  = decode_pkg::ALU_ADD;
        alt_sel = 1'b0;
        a_sel   = rs1_value;
        b_sel   = rs2_value;
        case (opcode)
            decode_pkg::OPCODE_OP: begin
                op_sel  = funct3;
                alt_sel = funct7_alt;
            end
            decode_pkg::OPCODE_IMM: begin
                op_sel  = funct3;
                alt_sel = funct7_alt && (funct3 == decode_pkg::ALU_SRL); // SRAI only
                b_sel   = imm;
            end
            decode_pkg::OPCODE_LUI: begin
                a_sel = '0;
                b_sel = imm;
            end
            decode_pkg::OPCODE_AUIPC: begin
                a_sel = instr_pc;
                b_sel = imm;
            end
            decode_pkg::OPCODE_JAL,
            decode_pkg::OPCODE_JALR: begin
                a_sel = instr_pc; // Link value
                b_sel = decode_pkg::reg_value_t'(`DEC_PC_STEP);
            end
            default: begin
                a_sel = rs1_value;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
            jump_valid <= 1'b0;
            retired    <= 1'b0;
        end else begin
            exec_valid <= issue && (rd != '0);
            jump_valid <= issue && is_jump;
            retired    <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            exec_rd        <= rd;
            exec_op        <= op_sel;
            exec_alternate <= alt_sel;
            exec_operand_a <= a_sel;
            exec_operand_b <= b_sel;
            exec_pc        <= instr_pc;
            jump_base      <= (opcode == decode_pkg::OPCODE_JALR) ? rs1_value : instr_pc;
            jump_offset    <= imm;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

`include "decode_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   clear,
    input  decode_pkg::reg_addr_t  clear_addr,
    input  logic                   wb_valid,
    input  decode_pkg::reg_addr_t  wb_addr,
    input  decode_pkg::reg_value_t wb_value,
    input  decode_pkg::reg_addr_t  rd_addr_a,
    input  decode_pkg::reg_addr_t  rd_addr_b,
    output decode_pkg::reg_value_t rd_data_a,
    output decode_pkg::reg_value_t rd_data_b
);

    decode_pkg::reg_value_t regs [`DEC_NUM_REGS];

    logic                   write_en;
    decode_pkg::reg_addr_t  write_addr;
    decode_pkg::reg_value_t write_data;

    // Reset sweep owns the write port while it runs
    always_comb begin
        if (clear) begin
            write_en   = 1'b1;
            write_addr = clear_addr;
            write_data = '0;
        end else begin
            write_en   = wb_valid && (wb_addr != '0);
            write_addr = wb_addr;
            write_data = wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

/* src/reg_scoreboard.sv */
`timescale 1ns/1ps

`include "decode_consts.svh"

module reg_scoreboard (
    input  logic                  clk,
    input  logic                  rst,
    input  decode_pkg::opcode_t   opcode,
    input  decode_pkg::reg_addr_t rd,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  logic                  issue,
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t wb_addr,
    output logic                  rs_ready,
    output logic                  all_clear
);

    decode_pkg::reg_status_t status [`DEC_NUM_REGS];
    decode_pkg::reg_status_t status_next [`DEC_NUM_REGS];

    logic rs1_valid;
    logic rs2_valid;
    logic rd_open;

    function automatic decode_pkg::reg_status_t issue_step(input decode_pkg::reg_status_t s);
        case (s)
            decode_pkg::REG_VALID:       return decode_pkg::REG_PENDING_ONE;
            decode_pkg::REG_PENDING_ONE: return decode_pkg::REG_PENDING_TWO;
            default:                     return s; // Blocked by rd_open
        endcase
    endfunction

    function automatic decode_pkg::reg_status_t wb_step(input decode_pkg::reg_status_t s);
        if (s == decode_pkg::REG_PENDING_TWO) begin
            return decode_pkg::REG_PENDING_ONE;
        end
        return decode_pkg::REG_VALID;
    endfunction

    assign rs1_valid = (status[rs1] == decode_pkg::REG_VALID);
    assign rs2_valid = (status[rs2] == decode_pkg::REG_VALID);
    // At most two writes in flight per register
    assign rd_open   = (status[rd] == decode_pkg::REG_VALID) ||
                       (status[rd] == decode_pkg::REG_PENDING_ONE);

    always_comb begin
        case (opcode)
            decode_pkg::OPCODE_OP:   rs_ready = rs1_valid && rs2_valid && rd_open;
            decode_pkg::OPCODE_IMM,
            decode_pkg::OPCODE_JALR: rs_ready = rs1_valid && rd_open;
            decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC,
            decode_pkg::OPCODE_JAL:  rs_ready = rd_open;
            default:                 rs_ready = 1'b1; // Halt or fault, no operands
        endcase
    end

    always_comb begin
        all_clear = 1'b1;
        for (int i = 0; i < `DEC_NUM_REGS; i++) begin
            if (status[i] != decode_pkg::REG_VALID) begin
                all_clear = 1'b0;
            end
        end
    end

    // Writeback steps down first, then a same-cycle issue steps up
    always_comb begin
        for (int i = 0; i < `DEC_NUM_REGS; i++) begin
            status_next[i] = status[i];
            if (wb_valid && wb_addr == decode_pkg::reg_addr_t'(i)) begin
                status_next[i] = wb_step(status_next[i]);
            end
            if (issue && rd == decode_pkg::reg_addr_t'(i)) begin
                status_next[i] = issue_step(status_next[i]);
            end
        end
        status_next[0] = decode_pkg::REG_VALID; // x0 never pends
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DEC_NUM_REGS; i++) begin
            if (rst) begin
                status[i] <= decode_pkg::REG_VALID;
            end else begin
                status[i] <= status_next[i];
            end
        end
    end

endmodule

/* src/rv_field_decoder.sv */
`timescale 1ns/1ps

module rv_field_decoder (
    input  logic [31:0]              instr_word,
    output decode_pkg::opcode_t      opcode,
    output decode_pkg::reg_addr_t    rd,
    output decode_pkg::reg_addr_t    rs1,
    output decode_pkg::reg_addr_t    rs2,
    output decode_pkg::alu_op_t      funct3,
    output logic                     funct7_alt,
    output decode_pkg::reg_value_t   imm,
    output decode_pkg::instr_class_t instr_class
);

    // EBREAK is the only SYSTEM word the stage accepts
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    assign opcode     = decode_pkg::opcode_t'(instr_word[6:0]);
    assign rd         = instr_word[11:7];
    assign rs1        = instr_word[19:15];
    assign rs2        = instr_word[24:20];
    assign funct3     = decode_pkg::alu_op_t'(instr_word[14:12]);
    assign funct7_alt = instr_word[30]; // SUB / SRA select

    always_comb begin
        case (opcode)
            decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC: begin
                imm = {instr_word[31:12], 12'b0}; // U-format
            end
            decode_pkg::OPCODE_JAL: begin
                // J-format, scrambled offset bits
                imm = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20],
                       instr_word[30:21], 1'b0};
            end
            default: begin
                imm = {{20{instr_word[31]}}, instr_word[31:20]}; // I-format
            end
        endcase
    end

    always_comb begin
        case (opcode)
            decode_pkg::OPCODE_OP,
            decode_pkg::OPCODE_IMM,
            decode_pkg::OPCODE_LUI,
            decode_pkg::OPCODE_AUIPC: begin
                instr_class = decode_pkg::CLASS_ALU;
            end
            decode_pkg::OPCODE_JAL,
            decode_pkg::OPCODE_JALR: begin
                instr_class = decode_pkg::CLASS_JUMP;
            end
            decode_pkg::OPCODE_SYSTEM: begin
                // ECALL and CSR ops fault
                if (instr_word == EBREAK_WORD) begin
                    instr_class = decode_pkg::CLASS_HALT;
                end else begin
                    instr_class = decode_pkg::CLASS_ILLEGAL;
                end
            end
            default: begin
                instr_class = decode_pkg::CLASS_ILLEGAL; // Branch, memory, fence, unknown
            end
        endcase
    end

endmodule

/* verification/decode_stage_tb.sv */
`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_stage_tb;

    // Longest path is two reset sweeps plus about a hundred issue cycles
    localparam int CYCLE_LIMIT = 2000;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic [31:0]            instr_word;
    decode_pkg::reg_value_t instr_pc;
    decode_pkg::jump_flag_t instr_jump_flag;
    logic                   instr_ready;
    logic                   wb_valid;
    decode_pkg::reg_addr_t  wb_addr;
    decode_pkg::reg_value_t wb_value;
    logic                   exec_valid;
    decode_pkg::reg_addr_t  exec_rd;
    decode_pkg::alu_op_t    exec_op;
    logic                   exec_alternate;
    decode_pkg::reg_value_t exec_operand_a;
    decode_pkg::reg_value_t exec_operand_b;
    decode_pkg::reg_value_t exec_pc;
    logic                   jump_valid;
    decode_pkg::reg_value_t jump_base;
    decode_pkg::reg_value_t jump_offset;
    logic                   retired;
    logic                   finished;
    logic                   faulted;

    int                     cycle_count;
    string                  test_name;
    decode_pkg::jump_flag_t cur_flag; // Expected stage epoch
    decode_pkg::reg_value_t x1_value;
    decode_pkg::reg_value_t x2_value;

    decode_stage decode_stage_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("TEST FAIL");
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $fatal(1);
        end
    end

    task automatic check_value(input string what, input decode_pkg::reg_value_t exp,
                               input decode_pkg::reg_value_t act);
        if (exp !== act) begin
            $display("TEST FAIL");
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string what, input decode_pkg::reg_addr_t exp,
                              input decode_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("TEST FAIL");
            $display("mismatch %s %s: expected x%0d actual x%0d", test_name, what, exp, act);
            $fatal(1);
        end
    endtask

    task automatic check_op(input string what, input decode_pkg::alu_op_t exp,
                            input decode_pkg::alu_op_t act);
        if (exp !== act) begin
            $display("TEST FAIL");
            $display("mismatch %s %s: expected %s actual %s", test_name, what,
                     exp.name(), act.name());
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("TEST FAIL");
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // J-format bit order from the ISA manual
    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // All tasks below start and end just after a falling edge
    task automatic apply_reset();
        rst         = 1'b1;
        instr_valid = 1'b0;
        wb_valid    = 1'b0;
        repeat (2) @(negedge clk);
        rst      = 1'b0;
        cur_flag = '0;
    endtask

    task automatic write_back(input decode_pkg::reg_addr_t addr,
                              input decode_pkg::reg_value_t value);
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_value = value;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic drive_instr(input logic [31:0] word, input decode_pkg::reg_value_t pc,
                               input decode_pkg::jump_flag_t flag);
        instr_valid     = 1'b1;
        instr_word      = word;
        instr_pc        = pc;
        instr_jump_flag = flag;
    endtask

    // Holds valid until ready, returns in the cycle after the transfer edge
    task automatic wait_transfer();
        forever begin
            #1;
            if (instr_ready) begin
                break;
            end
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic send_instr(input logic [31:0] word, input decode_pkg::reg_value_t pc,
                              input decode_pkg::jump_flag_t flag);
        drive_instr(word, pc, flag);
        wait_transfer();
    endtask

    task automatic expect_issue(input decode_pkg::reg_addr_t rd, input decode_pkg::alu_op_t op,
                                input logic alt, input decode_pkg::reg_value_t a,
                                input decode_pkg::reg_value_t b, input logic jump);
        check_bit("exec_valid", 1'b1, exec_valid);
        check_bit("retired", 1'b1, retired);
        check_bit("jump_valid", jump, jump_valid);
        check_addr("exec_rd", rd, exec_rd);
        check_op("exec_op", op, exec_op);
        check_bit("exec_alternate", alt, exec_alternate);
        check_value("exec_operand_a", a, exec_operand_a);
        check_value("exec_operand_b", b, exec_operand_b);
        @(negedge clk);
        check_bit("exec_valid strobe", 1'b0, exec_valid);
        check_bit("retired strobe", 1'b0, retired);
        check_bit("jump_valid strobe", 1'b0, jump_valid);
    endtask

    task automatic test_reset_clear();
        test_name = "reset_clear";
        send_instr(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, decode_pkg::OPCODE_OP), 32'h0, cur_flag);
        expect_issue(5'd3, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'h0, 1'b0);
        write_back(5'd3, 32'h0);
    endtask

    task automatic test_writeback_issue();
        test_name = "writeback_issue";
        x1_value  = $urandom;
        x2_value  = $urandom;
        write_back(5'd1, x1_value);
        write_back(5'd2, x2_value);
        send_instr(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd4, decode_pkg::OPCODE_OP), 32'h10, cur_flag);
        expect_issue(5'd4, decode_pkg::ALU_ADD, 1'b0, x1_value, x2_value, 1'b0);
        send_instr(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd5, decode_pkg::OPCODE_OP), 32'h14, cur_flag);
        expect_issue(5'd5, decode_pkg::ALU_ADD, 1'b1, x1_value, x2_value, 1'b0);
        // ADDI with a negative immediate
        send_instr(i_type(12'hFFB, 5'd1, 3'd0, 5'd6, decode_pkg::OPCODE_IMM), 32'h18, cur_flag);
        expect_issue(5'd6, decode_pkg::ALU_ADD, 1'b0, x1_value, 32'hFFFF_FFFB, 1'b0);
        send_instr(i_type(12'h403, 5'd2, 3'd5, 5'd7, decode_pkg::OPCODE_IMM), 32'h1C, cur_flag);
        expect_issue(5'd7, decode_pkg::ALU_SRL, 1'b1, x2_value, 32'h0000_0403, 1'b0);
        // Bit 30 set on ADDI is just immediate
        send_instr(i_type(12'h400, 5'd1, 3'd0, 5'd8, decode_pkg::OPCODE_IMM), 32'h20, cur_flag);
        expect_issue(5'd8, decode_pkg::ALU_ADD, 1'b0, x1_value, 32'h0000_0400, 1'b0);
        send_instr(u_type(20'h12345, 5'd9, decode_pkg::OPCODE_LUI), 32'h24, cur_flag);
        expect_issue(5'd9, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'h1234_5000, 1'b0);
        send_instr(u_type(20'hABCDE, 5'd10, decode_pkg::OPCODE_AUIPC), 32'h100, cur_flag);
        check_value("exec_pc", 32'h100, exec_pc);
        expect_issue(5'd10, decode_pkg::ALU_ADD, 1'b0, 32'h100, 32'hABCD_E000, 1'b0);
        for (int r = 4; r <= 10; r++) begin
            write_back(decode_pkg::reg_addr_t'(r), decode_pkg::reg_value_t'(r * 3));
        end
    endtask

    task automatic test_hazard_stall();
        decode_pkg::reg_value_t x5_value;
        test_name = "hazard_stall";
        x5_value  = $urandom;
        send_instr(i_type(12'd7, 5'd0, 3'd0, 5'd5, decode_pkg::OPCODE_IMM), 32'h200, cur_flag);
        expect_issue(5'd5, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'd7, 1'b0);
        drive_instr(r_type(7'h00, 5'd1, 5'd5, 3'd0, 5'd6, decode_pkg::OPCODE_OP), 32'h204,
                    cur_flag);
        repeat (3) begin
            #1;
            check_bit("instr_ready with x5 pending", 1'b0, instr_ready);
            @(negedge clk);
        end
        wb_valid = 1'b1;
        wb_addr  = 5'd5;
        wb_value = x5_value;
        #1;
        check_bit("instr_ready during writeback", 1'b0, instr_ready);
        @(negedge clk);
        wb_valid = 1'b0;
        wait_transfer();
        expect_issue(5'd6, decode_pkg::ALU_ADD, 1'b0, x5_value, x1_value, 1'b0);
        write_back(5'd6, 32'h0);
    endtask

    task automatic test_jump_flag();
        logic [20:0]            off;
        decode_pkg::reg_value_t pc;
        test_name = "jump_flag";
        off       = 21'h1F_0ABC;
        pc        = 32'h0000_0200;
        send_instr(j_type(off, 5'd1), pc, cur_flag);
        check_value("jump_base", pc, jump_base);
        check_value("jump_offset", {{11{off[20]}}, off}, jump_offset);
        expect_issue(5'd1, decode_pkg::ALU_ADD, 1'b0, pc, `DEC_PC_STEP, 1'b1);
        // Wrong-path word with the old epoch
        send_instr(i_type(12'd9, 5'd0, 3'd0, 5'd2, decode_pkg::OPCODE_IMM), 32'h204, cur_flag);
        check_bit("dropped exec_valid", 1'b0, exec_valid);
        check_bit("dropped retired", 1'b0, retired);
        check_bit("dropped jump_valid", 1'b0, jump_valid);
        cur_flag = cur_flag + 1'b1;
        send_instr(i_type(12'd9, 5'd0, 3'd0, 5'd2, decode_pkg::OPCODE_IMM), 32'hABC, cur_flag);
        expect_issue(5'd2, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'd9, 1'b0);
        write_back(5'd1, pc + `DEC_PC_STEP);
        write_back(5'd2, 32'd9);
    endtask

    task automatic test_halt_fault();
        test_name = "halt_fault";
        send_instr(i_type(12'd1, 5'd0, 3'd0, 5'd11, decode_pkg::OPCODE_IMM), 32'h300, cur_flag);
        expect_issue(5'd11, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'd1, 1'b0);
        send_instr(32'h0010_0073, 32'h304, cur_flag); // EBREAK
        check_bit("retired on EBREAK", 1'b0, retired);
        check_bit("finished with x11 pending", 1'b0, finished);
        check_bit("faulted in halt", 1'b0, faulted);
        #1;
        check_bit("instr_ready in halt", 1'b0, instr_ready);
        @(negedge clk);
        write_back(5'd11, 32'd1);
        check_bit("finished after writeback", 1'b1, finished);
        check_bit("faulted after halt", 1'b0, faulted);

        apply_reset();
        check_bit("faulted after reset", 1'b0, faulted);
        check_bit("finished after reset", 1'b0, finished);
        // x1 and x2 held nonzero values before this reset
        send_instr(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, decode_pkg::OPCODE_OP), 32'h0, cur_flag);
        expect_issue(5'd3, decode_pkg::ALU_ADD, 1'b0, 32'h0, 32'h0, 1'b0);
        write_back(5'd3, 32'h0);
        // LW x12, 4(x1)
        send_instr(i_type(12'd4, 5'd1, 3'd2, 5'd12, decode_pkg::OPCODE_LOAD), 32'h4, cur_flag);
        check_bit("exec_valid on load", 1'b0, exec_valid);
        check_bit("retired on load", 1'b0, retired);
        check_bit("faulted on load", 1'b1, faulted);
        check_bit("finished on load", 1'b1, finished);
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr_word      = '0;
        instr_pc        = '0;
        instr_jump_flag = '0;
        wb_valid        = 1'b0;
        wb_addr         = '0;
        wb_value        = '0;
        cycle_count     = 0;
        cur_flag        = '0;
        void'($urandom(18));
        apply_reset();
        test_reset_clear();
        test_writeback_issue();
        test_hazard_stall();
        test_jump_flag();
        test_halt_fault();
        $display("TEST PASS");
        $finish;
    end

endmodule
